//--- design/vision_pkg.sv
// vision path constants: orange colour window, line and zone geometry
// and the steering direction encoding shared by the classifier and the FSM
`default_nettype none

package vision_pkg;

  // orange window on decoded 8-bit channels
  localparam logic [7:0] RED_MIN   = 8'd180;
  localparam logic [7:0] GREEN_MIN = 8'd60;
  localparam logic [7:0] GREEN_MAX = 8'd150;
  localparam logic [7:0] BLUE_MAX  = 8'd90;

  // active pixels per line, three equal column zones
  localparam logic [7:0] LINE_WIDTH = 8'd96;
  localparam logic [7:0] ZONE_WIDTH = 8'd32;

  // per-zone hit counter width
  localparam int HIT_WIDTH = 16;

  // fewer orange pixels than this per frame means no target
  localparam logic [HIT_WIDTH-1:0] MIN_HITS = 16'd8;

  // steering verdict produced once per frame
  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_LEFT,
    DIR_CENTER,
    DIR_RIGHT
  } direction_t;

endpackage

`default_nettype wire

//--- design/drive_pkg.sv
// audio and drive control definitions: loudness window, remote button
// codes and the drive FSM state and command encodings
`default_nettype none

package drive_pkg;

  // samples per loudness measurement and the counter that spans them
  localparam int LEVEL_WINDOW    = 64;
  localparam int LEVEL_CNT_WIDTH = 6;

  // decoded remote control buttons
  typedef enum logic [2:0] {
    IR_STOP,
    IR_MANUAL,
    IR_TRACK,
    IR_FWD,
    IR_LEFT,
    IR_RIGHT
  } ir_code_t;

  // operating modes
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_MANUAL,
    ST_TRACK
  } drive_state_t;

  // command presented to the motor driver
  typedef enum logic [1:0] {
    DRV_STOP,
    DRV_FWD,
    DRV_LEFT,
    DRV_RIGHT
  } drive_cmd_t;

endpackage

`default_nettype wire

//--- design/target_finder.sv
// flags orange pixels in the video stream and paints them pure red
// result and recoloured pixel appear one cycle after the input pixel
`timescale 1ns/1ps
`default_nettype none

module target_finder (
  input  wire        clk_50,
  input  wire        reset,
  input  wire        pixel_valid,
  input  wire  [7:0] red_in,
  input  wire  [7:0] green_in,
  input  wire  [7:0] blue_in,
  output logic       pixel_out_valid,
  output logic [7:0] red_out,
  output logic [7:0] green_out,
  output logic [7:0] blue_out,
  output logic       is_orange
);

  import vision_pkg::*;

  // combinational threshold test on the incoming pixel
  logic red_ok;
  logic green_ok;
  logic blue_ok;
  logic orange_now;

  always_comb begin
    // strong red channel
    red_ok     = (red_in >= RED_MIN);
    // green inside the window, both ends inclusive
    green_ok   = (green_in >= GREEN_MIN) && (green_in <= GREEN_MAX);
    // little blue
    blue_ok    = (blue_in <= BLUE_MAX);
    // only a valid pixel can be a hit
    orange_now = pixel_valid && red_ok && green_ok && blue_ok;
  end

  // control outputs, cleared by reset
  always_ff @(posedge clk_50) begin
    if (reset) begin
      pixel_out_valid <= 1'b0;
      is_orange       <= 1'b0;
    end else begin
      pixel_out_valid <= pixel_valid;
      is_orange       <= orange_now;
    end
  end

  // pixel payload
  always_ff @(posedge clk_50) begin
    if (!pixel_valid) begin
      // blank between pixels
      red_out   <= 8'h00;
      green_out <= 8'h00;
      blue_out  <= 8'h00;
    end else if (orange_now) begin
      // highlight the target in pure red
      red_out   <= 8'hff;
      green_out <= 8'h00;
      blue_out  <= 8'h00;
    end else begin
      // everything else passes unchanged
      red_out   <= red_in;
      green_out <= green_in;
      blue_out  <= blue_in;
    end
  end

endmodule

`default_nettype wire

//--- design/classification.sv
// counts orange hits per column zone across a frame and picks a steering
// direction at frame end; dir_valid pulses one cycle after frame_end
`timescale 1ns/1ps
`default_nettype none

module classification (
  input  wire                    clk_50,
  input  wire                    reset,
  input  wire                    pixel_valid,
  input  wire                    is_orange,
  input  wire                    line_start,
  input  wire                    frame_end,
  output vision_pkg::direction_t direction,
  output logic                   dir_valid
);

  import vision_pkg::*;

  // column position within the current line
  logic [7:0] column;

  // orange hits per zone for the current frame
  logic [HIT_WIDTH-1:0] left_hits;
  logic [HIT_WIDTH-1:0] center_hits;
  logic [HIT_WIDTH-1:0] right_hits;

  // sum of all zones, two extra bits so it cannot wrap
  logic [HIT_WIDTH+1:0] total_hits;

  // verdict for the frame being closed
  direction_t frame_dir;

  // column is inside the active line
  logic in_line;

  always_comb begin
    in_line    = (column < LINE_WIDTH);
    total_hits = {2'b00, left_hits} + {2'b00, center_hits} + {2'b00, right_hits};

    // too few hits means no target at all
    if (total_hits < {2'b00, MIN_HITS}) begin
      frame_dir = DIR_NONE;
    // ties go to center first
    end else if ((center_hits >= left_hits) && (center_hits >= right_hits)) begin
      frame_dir = DIR_CENTER;
    // then left wins over right
    end else if (left_hits >= right_hits) begin
      frame_dir = DIR_LEFT;
    end else begin
      frame_dir = DIR_RIGHT;
    end
  end

  // column counter, restarted at each line
  always_ff @(posedge clk_50) begin
    if (reset || line_start || frame_end) begin
      column <= 8'd0;
    end else if (pixel_valid && in_line) begin
      column <= column + 8'd1;
    end
  end

  // zone counters and frame decision
  always_ff @(posedge clk_50) begin
    if (reset) begin
      left_hits   <= '0;
      center_hits <= '0;
      right_hits  <= '0;
      direction   <= DIR_NONE;
      dir_valid   <= 1'b0;
    end else if (frame_end) begin
      // close the frame and start over
      direction   <= frame_dir;
      dir_valid   <= 1'b1;
      left_hits   <= '0;
      center_hits <= '0;
      right_hits  <= '0;
    end else begin
      dir_valid <= 1'b0;
      if (pixel_valid && is_orange && in_line) begin
        // 0..31 left, 32..63 center, 64..95 right
        if (column < ZONE_WIDTH) begin
          left_hits <= left_hits + 1'b1;
        end else if (column < (ZONE_WIDTH + ZONE_WIDTH)) begin
          center_hits <= center_hits + 1'b1;
        end else begin
          right_hits <= right_hits + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/mic_level.sv
// peak loudness meter for signed audio samples; at the end of each window
// it updates a 4-bit level and a 2-bit speed and pulses level_valid
`timescale 1ns/1ps
`default_nettype none

module mic_level (
  input  wire               clk_50,
  input  wire               reset,
  input  wire               sample_valid,
  input  wire signed [15:0] sample,
  output logic        [3:0] mapped_level,
  output logic        [1:0] speed,
  output logic              level_valid
);

  import drive_pkg::*;

  // position within the current window
  logic [LEVEL_CNT_WIDTH-1:0] sample_cnt;

  // largest magnitude seen so far in the window
  logic [14:0] peak;

  // magnitude of the incoming sample
  logic [15:0] sample_neg;
  logic [14:0] magnitude;

  // peak including the current sample
  logic [14:0] peak_next;

  // this sample completes the window
  logic window_done;

  always_comb begin
    sample_neg = -sample;
    if (sample[15] && (sample[14:0] == 15'd0)) begin
      // -32768 has no positive twin, clamp it
      magnitude = 15'h7fff;
    end else if (sample[15]) begin
      magnitude = sample_neg[14:0];
    end else begin
      magnitude = sample[14:0];
    end

    peak_next   = (magnitude > peak) ? magnitude : peak;
    window_done = (sample_cnt == LEVEL_CNT_WIDTH'(LEVEL_WINDOW - 1));
  end

  always_ff @(posedge clk_50) begin
    if (reset) begin
      sample_cnt   <= '0;
      peak         <= 15'd0;
      mapped_level <= 4'd0;
      speed        <= 2'd0;
      level_valid  <= 1'b0;
    end else begin
      level_valid <= 1'b0;
      if (sample_valid) begin
        if (window_done) begin
          // publish the level and hold it until the next window
          mapped_level <= peak_next[14:11];
          // speed is the top half of the level
          speed        <= peak_next[14:13];
          level_valid  <= 1'b1;
          peak         <= 15'd0;
          sample_cnt   <= '0;
        end else begin
          peak       <= peak_next;
          sample_cnt <= sample_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/drive_fsm.sv
// rover mode FSM: remote buttons select idle, manual or tracking mode,
// tracking follows the camera direction; outputs update one cycle later
`timescale 1ns/1ps
`default_nettype none

module drive_fsm (
  input  wire                      clk_50,
  input  wire                      reset,
  input  wire                      ir_valid,
  input  wire drive_pkg::ir_code_t ir_code,
  input  wire                      dir_valid,
  input  wire vision_pkg::direction_t direction,
  input  wire                [1:0] speed,
  output drive_pkg::drive_state_t  state,
  output drive_pkg::drive_cmd_t    drive_cmd,
  output logic               [1:0] drive_speed
);

  import vision_pkg::*;
  import drive_pkg::*;

  drive_state_t state_next;
  drive_cmd_t   cmd_next;

  always_comb begin
    // hold by default
    state_next = state;
    cmd_next   = drive_cmd;

    // button codes are applied first
    if (ir_valid) begin
      case (ir_code)
        // mode codes always stop the motors
        IR_STOP: begin
          state_next = ST_IDLE;
          cmd_next   = DRV_STOP;
        end
        IR_MANUAL: begin
          state_next = ST_MANUAL;
          cmd_next   = DRV_STOP;
        end
        IR_TRACK: begin
          state_next = ST_TRACK;
          cmd_next   = DRV_STOP;
        end
        // motion buttons only count in manual mode
        IR_FWD: begin
          if (state == ST_MANUAL) cmd_next = DRV_FWD;
        end
        IR_LEFT: begin
          if (state == ST_MANUAL) cmd_next = DRV_LEFT;
        end
        IR_RIGHT: begin
          if (state == ST_MANUAL) cmd_next = DRV_RIGHT;
        end
        // unused codes are ignored
        default: begin
          state_next = state;
        end
      endcase
    end

    // camera verdict is judged in the state just chosen
    if (dir_valid && (state_next == ST_TRACK)) begin
      case (direction)
        DIR_LEFT:   cmd_next = DRV_LEFT;
        DIR_CENTER: cmd_next = DRV_FWD;
        DIR_RIGHT:  cmd_next = DRV_RIGHT;
        default:    cmd_next = DRV_STOP;
      endcase
    end
  end

  always_ff @(posedge clk_50) begin
    if (reset) begin
      state       <= ST_IDLE;
      drive_cmd   <= DRV_STOP;
      drive_speed <= 2'd0;
    end else begin
      state       <= state_next;
      drive_cmd   <= cmd_next;
      // speed follows the loudness while moving
      drive_speed <= (cmd_next != DRV_STOP) ? speed : 2'd0;
    end
  end

endmodule

`default_nettype wire

//--- design/rover_top.sv
// rover perception and steering core: vision path, audio path and the
// drive FSM that combines them, all on clk_50
`timescale 1ns/1ps
`default_nettype none

module rover_top (
  input  wire                        clk_50,
  input  wire                        reset,
  input  wire                        pixel_valid,
  input  wire                  [7:0] red_in,
  input  wire                  [7:0] green_in,
  input  wire                  [7:0] blue_in,
  input  wire                        line_start,
  input  wire                        frame_end,
  input  wire                        sample_valid,
  input  wire signed          [15:0] sample,
  input  wire                        ir_valid,
  input  wire drive_pkg::ir_code_t   ir_code,
  output wire                  [7:0] red_out,
  output wire                  [7:0] green_out,
  output wire                  [7:0] blue_out,
  output wire                        pixel_out_valid,
  output vision_pkg::direction_t     direction,
  output wire                        dir_valid,
  output wire                  [3:0] mapped_level,
  output wire                        level_valid,
  output drive_pkg::drive_state_t    state,
  output drive_pkg::drive_cmd_t      drive_cmd,
  output wire                  [1:0] drive_speed
);

  // orange flag aligned with the recoloured pixel
  wire       is_orange;
  // speed from the loudness meter
  wire [1:0] speed;

  // pixel test and recolouring
  target_finder u_target_finder (
    .clk_50          (clk_50),
    .reset           (reset),
    .pixel_valid     (pixel_valid),
    .red_in          (red_in),
    .green_in        (green_in),
    .blue_in         (blue_in),
    .pixel_out_valid (pixel_out_valid),
    .red_out         (red_out),
    .green_out       (green_out),
    .blue_out        (blue_out),
    .is_orange       (is_orange)
  );

  // zone counting on the delayed pixel stream
  classification u_classification (
    .clk_50      (clk_50),
    .reset       (reset),
    .pixel_valid (pixel_out_valid),
    .is_orange   (is_orange),
    .line_start  (line_start),
    .frame_end   (frame_end),
    .direction   (direction),
    .dir_valid   (dir_valid)
  );

  // loudness to speed
  mic_level u_mic_level (
    .clk_50       (clk_50),
    .reset        (reset),
    .sample_valid (sample_valid),
    .sample       (sample),
    .mapped_level (mapped_level),
    .speed        (speed),
    .level_valid  (level_valid)
  );

  // mode and command decision
  drive_fsm u_drive_fsm (
    .clk_50      (clk_50),
    .reset       (reset),
    .ir_valid    (ir_valid),
    .ir_code     (ir_code),
    .dir_valid   (dir_valid),
    .direction   (direction),
    .speed       (speed),
    .state       (state),
    .drive_cmd   (drive_cmd),
    .drive_speed (drive_speed)
  );

endmodule

`default_nettype wire

//--- verif/rover_model.svh
// reference model for the rover core, included inside the testbench module
// colour rule, zone verdict, audio magnitude and drive FSM decisions
`ifndef ROVER_MODEL_SVH
`define ROVER_MODEL_SVH
`default_nettype none

// orange window on the raw channels, both green limits inclusive
function automatic logic is_orange_rgb(input logic [7:0] r, input logic [7:0] g,
                                       input logic [7:0] b);
  return (r >= RED_MIN) && (g >= GREEN_MIN) && (g <= GREEN_MAX) && (b <= BLUE_MAX);
endfunction

// expected output pixel as {red, green, blue}
function automatic logic [23:0] recolour(input logic valid, input logic [7:0] r,
                                         input logic [7:0] g, input logic [7:0] b);
  if (!valid) return 24'h000000;
  // targets are painted pure red
  if (is_orange_rgb(r, g, b)) return 24'hff0000;
  return {r, g, b};
endfunction

// frame verdict, ties go center first, then left
function automatic direction_t pick_direction(input int left, input int center, input int right);
  if (left + center + right < MIN_HITS) return DIR_NONE;
  if (center >= left && center >= right) return DIR_CENTER;
  if (left >= right) return DIR_LEFT;
  return DIR_RIGHT;
endfunction

// magnitude of a signed sample, the most negative value clamps to 7fff
function automatic logic [14:0] sample_magnitude(input logic signed [15:0] s);
  int v;
  v = s;
  if (v < 0) v = -v;
  if (v > 32767) v = 32767;
  return v[14:0];
endfunction

// next {state, command}; buttons first, then the direction in the new state
function automatic logic [3:0] next_drive(input drive_state_t st, input drive_cmd_t cmd,
                                          input logic ir_on, input ir_code_t code,
                                          input logic dir_on, input direction_t dir);
  drive_state_t ns;
  drive_cmd_t nc;
  ns = st;
  nc = cmd;
  if (ir_on) begin
    case (code)
      IR_STOP: begin
        ns = ST_IDLE;
        nc = DRV_STOP;
      end
      IR_MANUAL: begin
        ns = ST_MANUAL;
        nc = DRV_STOP;
      end
      IR_TRACK: begin
        ns = ST_TRACK;
        nc = DRV_STOP;
      end
      // motion codes only matter in manual mode
      IR_FWD: if (st == ST_MANUAL) nc = DRV_FWD;
      IR_LEFT: if (st == ST_MANUAL) nc = DRV_LEFT;
      IR_RIGHT: if (st == ST_MANUAL) nc = DRV_RIGHT;
      default: ns = st;
    endcase
  end
  if (dir_on && ns == ST_TRACK) begin
    case (dir)
      DIR_LEFT: nc = DRV_LEFT;
      DIR_CENTER: nc = DRV_FWD;
      DIR_RIGHT: nc = DRV_RIGHT;
      default: nc = DRV_STOP;
    endcase
  end
  return {ns, nc};
endfunction

`default_nettype wire
`endif

//--- verif/rover_tb.sv
// testbench for rover_top that drives random pixels, frames, audio and button codes
// and compares every output each cycle against the included reference model
`timescale 1ns/1ps
`default_nettype none

module rover_tb;

  import vision_pkg::*;
  import drive_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int PIX_LINES     = 4;
  localparam int STEER_FRAMES  = 12;
  localparam int AUDIO_WINDOWS = 4;
  localparam int MANUAL_STEPS  = 40;
  localparam int TRACK_FRAMES  = 6;
  // worst case line has a gap before every pixel plus line start and trailing idle
  localparam int LINE_CYCLES   = 2 * 96 + 2;
  // up to 4 lines, then idle, frame end, button slot and one settle cycle
  localparam int FRAME_CYCLES  = 4 * LINE_CYCLES + 5;
  localparam int RUN_CYCLES    = 20 + (PIX_LINES + 1) * LINE_CYCLES
                                 + STEER_FRAMES * FRAME_CYCLES + AUDIO_WINDOWS * 64 * 4
                                 + MANUAL_STEPS * 2 + 10 + TRACK_FRAMES * (FRAME_CYCLES + 1);
  localparam longint TIMEOUT_NS = 2 * RUN_CYCLES * CLK_PERIOD;

  // DUT ports
  logic clk_50;
  logic reset;
  logic pixel_valid;
  logic [7:0] red_in;
  logic [7:0] green_in;
  logic [7:0] blue_in;
  logic line_start;
  logic frame_end;
  logic sample_valid;
  logic signed [15:0] sample;
  logic ir_valid;
  ir_code_t ir_code;
  wire [7:0] red_out;
  wire [7:0] green_out;
  wire [7:0] blue_out;
  wire pixel_out_valid;
  direction_t direction;
  wire dir_valid;
  wire [3:0] mapped_level;
  wire level_valid;
  drive_state_t state;
  drive_cmd_t drive_cmd;
  wire [1:0] drive_speed;

  // staged inputs for the next falling edge
  logic d_pixel_valid;
  logic [7:0] d_red;
  logic [7:0] d_green;
  logic [7:0] d_blue;
  logic d_line_start;
  logic d_frame_end;
  logic d_sample_valid;
  logic signed [15:0] d_sample;
  logic d_ir_valid;
  ir_code_t d_ir_code;

  // model state and expected outputs
  logic exp_pov = 1'b0;
  logic [23:0] exp_rgb = 24'h0;
  logic exp_dir_valid = 1'b0;
  direction_t exp_direction = DIR_NONE;
  logic exp_level_valid = 1'b0;
  logic [3:0] exp_level = 4'd0;
  drive_state_t exp_state = ST_IDLE;
  drive_cmd_t exp_cmd = DRV_STOP;
  logic [1:0] exp_dspeed = 2'd0;
  int col = 0;
  int hits_l = 0;
  int hits_c = 0;
  int hits_r = 0;
  int smp_cnt = 0;
  logic [14:0] peak = 15'd0;

  int errors = 0;
  int mark_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int unsigned rand_state = 32'h83ca;

  rover_top UUT (
    .clk_50(clk_50), .reset(reset), .pixel_valid(pixel_valid), .red_in(red_in),
    .green_in(green_in), .blue_in(blue_in), .line_start(line_start),
    .frame_end(frame_end), .sample_valid(sample_valid), .sample(sample),
    .ir_valid(ir_valid), .ir_code(ir_code), .red_out(red_out), .green_out(green_out),
    .blue_out(blue_out), .pixel_out_valid(pixel_out_valid), .direction(direction),
    .dir_valid(dir_valid), .mapped_level(mapped_level), .level_valid(level_valid),
    .state(state), .drive_cmd(drive_cmd), .drive_speed(drive_speed)
  );

  initial begin
    clk_50 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_50 = ~clk_50;
  end

  // hang guard sized from the worst-case test lengths
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

  // 32-bit xorshift
  function automatic int unsigned next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_outputs();
    expect_equal("pixel_out_valid", pixel_out_valid, exp_pov);
    expect_equal("red_out", red_out, exp_rgb[23:16]);
    expect_equal("green_out", green_out, exp_rgb[15:8]);
    expect_equal("blue_out", blue_out, exp_rgb[7:0]);
    expect_equal("dir_valid", dir_valid, exp_dir_valid);
    expect_equal("direction", direction, exp_direction);
    expect_equal("level_valid", level_valid, exp_level_valid);
    expect_equal("mapped_level", mapped_level, exp_level);
    expect_equal("state", state, exp_state);
    expect_equal("drive_cmd", drive_cmd, exp_cmd);
    expect_equal("drive_speed", drive_speed, exp_dspeed);
  endtask

  // one clock that checks the last results, advances the model and drives inputs
  task automatic step_cycle();
    logic [3:0] fsm_next;
    logic [14:0] mag;
    @(negedge clk_50);
    compare_outputs();
    // FSM sees this cycle's dir_valid and the speed still held by the meter
    fsm_next = next_drive(exp_state, exp_cmd, d_ir_valid, d_ir_code,
                          exp_dir_valid, exp_direction);
    exp_state  = drive_state_t'(fsm_next[3:2]);
    exp_cmd    = drive_cmd_t'(fsm_next[1:0]);
    exp_dspeed = (exp_cmd != DRV_STOP) ? exp_level[3:2] : 2'd0;
    exp_pov = d_pixel_valid;
    exp_rgb = recolour(d_pixel_valid, d_red, d_green, d_blue);
    // zone counting with columns 0..31 left, 32..63 center and 64..95 right
    exp_dir_valid = 1'b0;
    if (d_frame_end) begin
      exp_direction = pick_direction(hits_l, hits_c, hits_r);
      exp_dir_valid = 1'b1;
      hits_l = 0;
      hits_c = 0;
      hits_r = 0;
      col = 0;
    end else if (d_line_start) begin
      col = 0;
    end else if (d_pixel_valid) begin
      if (is_orange_rgb(d_red, d_green, d_blue)) begin
        if (col < 32) hits_l++;
        else if (col < 64) hits_c++;
        else hits_r++;
      end
      col++;
    end
    // audio window
    exp_level_valid = 1'b0;
    if (d_sample_valid) begin
      mag = sample_magnitude(d_sample);
      if (mag > peak) peak = mag;
      smp_cnt++;
      if (smp_cnt == LEVEL_WINDOW) begin
        exp_level = peak[14:11];
        exp_level_valid = 1'b1;
        peak = 15'd0;
        smp_cnt = 0;
      end
    end
    pixel_valid  = d_pixel_valid;
    red_in       = d_red;
    green_in     = d_green;
    blue_in      = d_blue;
    line_start   = d_line_start;
    frame_end    = d_frame_end;
    sample_valid = d_sample_valid;
    sample       = d_sample;
    ir_valid     = d_ir_valid;
    ir_code      = d_ir_code;
    // strobes last one cycle
    d_pixel_valid  = 1'b0;
    d_line_start   = 1'b0;
    d_frame_end    = 1'b0;
    d_sample_valid = 1'b0;
    d_ir_valid     = 1'b0;
  endtask

  task automatic drive_orange_pixel();
    int unsigned r;
    r = next_random();
    d_red   = 8'd180 + (r[7:0] % 76);
    d_green = 8'd60 + (r[15:8] % 91);
    d_blue  = r[23:16] % 91;
    d_pixel_valid = 1'b1;
  endtask

  // one channel pushed outside its window so this pixel is never a hit
  task automatic drive_plain_pixel();
    int unsigned r;
    r = next_random();
    d_red   = r[7:0];
    d_green = r[15:8];
    d_blue  = r[23:16];
    case (r[25:24])
      2'd0: d_red = r[7:0] % 180;
      2'd1: d_green = r[15:8] % 60;
      2'd2: d_green = 8'd151 + (r[15:8] % 105);
      default: d_blue = 8'd91 + (r[23:16] % 165);
    endcase
    d_pixel_valid = 1'b1;
  endtask

  // with fixed set the first k columns of each zone are orange, otherwise k/16 density
  task automatic send_line(input bit fixed, input int kl, input int kc, input int kr);
    int c;
    int k;
    bit hit;
    d_line_start = 1'b1;
    step_cycle();
    for (c = 0; c < 96; c++) begin
      if (next_random() % 8 == 0) step_cycle();
      k = (c < 32) ? kl : ((c < 64) ? kc : kr);
      if (fixed) hit = ((c % 32) < k);
      else hit = ((next_random() % 16) < k);
      if (hit) drive_orange_pixel();
      else drive_plain_pixel();
      step_cycle();
    end
    // idle so the next line start misses the last delayed pixel
    step_cycle();
  endtask

  // frame end followed by an optional button in the dir_valid cycle
  task automatic close_frame(input bit ir_on, input ir_code_t code);
    step_cycle();
    d_frame_end = 1'b1;
    step_cycle();
    d_ir_valid = ir_on;
    d_ir_code  = code;
    step_cycle();
    step_cycle();
  endtask

  task automatic send_frame(input bit ir_on, input ir_code_t code);
    int mode;
    int lines;
    int k;
    int kl;
    int kc;
    int kr;
    int i;
    mode  = next_random() % 3;
    lines = 2 + next_random() % 3;
    if (mode == 0) begin
      kl = next_random() % 16;
      kc = next_random() % 16;
      kr = next_random() % 16;
    end else if (mode == 1) begin
      // at most 6 hits so no target is found
      lines = 2;
      kl = next_random() % 2;
      kc = next_random() % 2;
      kr = next_random() % 2;
    end else begin
      // exact ties between two or three zones
      k = 4 + next_random() % 8;
      kl = k;
      kc = k;
      kr = k;
      case (next_random() % 3)
        0: kr = next_random() % k;
        1: kc = next_random() % k;
        default: kl = k;
      endcase
    end
    for (i = 0; i < lines; i++) send_line(mode != 0, kl, kc, kr);
    close_frame(ir_on, code);
  endtask

  task automatic end_test(input string name);
    if (errors == mark_errors) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d mismatches", name, errors - mark_errors);
    end
    mark_errors = errors;
  endtask

  initial begin
    int i;
    int w;
    int shift;
    int unsigned r;
    ir_code_t code;
    reset = 1'b1;
    {pixel_valid, red_in, green_in, blue_in, line_start, frame_end} = '0;
    {sample_valid, sample, ir_valid} = '0;
    ir_code = IR_STOP;
    {d_pixel_valid, d_red, d_green, d_blue, d_line_start, d_frame_end} = '0;
    {d_sample_valid, d_sample, d_ir_valid} = '0;
    d_ir_code = IR_STOP;
    repeat (8) @(posedge clk_50);
    @(negedge clk_50);
    reset = 1'b0;

    step_cycle();
    end_test("reset values");

    // about half the pixels orange in every zone
    for (i = 0; i < PIX_LINES; i++) send_line(1'b0, 8, 8, 8);
    close_frame(1'b0, IR_STOP);
    end_test("pixel recolouring");

    for (i = 0; i < STEER_FRAMES; i++) send_frame(1'b0, IR_STOP);
    end_test("steering decision");

    for (w = 0; w < AUDIO_WINDOWS; w++) begin
      // every window has its own loudness and the last one sits near half scale
      shift = (AUDIO_WINDOWS - w) % 4;
      for (i = 0; i < 64; i++) begin
        repeat (next_random() % 4) step_cycle();
        r = next_random();
        // the first window holds the full-scale negative value
        if (w == 0 && i == 32) d_sample = 16'sh8000;
        else d_sample = $signed(r[31:16]) >>> shift;
        d_sample_valid = 1'b1;
        step_cycle();
      end
    end
    step_cycle();
    end_test("loudness level");

    d_ir_valid = 1'b1;
    d_ir_code  = IR_MANUAL;
    step_cycle();
    for (i = 0; i < MANUAL_STEPS; i++) begin
      r = next_random();
      if (exp_state != ST_MANUAL && r[0]) code = IR_MANUAL;
      else if (r[7:4] == 4'd0) code = ir_code_t'(r[9:8] % 3);
      else code = ir_code_t'(3 + r[13:12] % 3);
      d_ir_valid = 1'b1;
      d_ir_code  = code;
      step_cycle();
      if (r[16]) step_cycle();
    end
    step_cycle();
    end_test("manual mode");

    d_ir_valid = 1'b1;
    d_ir_code  = IR_TRACK;
    step_cycle();
    for (i = 0; i < TRACK_FRAMES; i++) begin
      if (exp_state != ST_TRACK) begin
        d_ir_valid = 1'b1;
        d_ir_code  = IR_TRACK;
        step_cycle();
      end
      r = next_random();
      send_frame(r[0], ir_code_t'(r[10:8] % 6));
    end
    end_test("tracking mode");

    $display("%0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  `include "rover_model.svh"

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verif
design/vision_pkg.sv
design/drive_pkg.sv
design/target_finder.sv
design/classification.sv
design/mic_level.sv
design/drive_fsm.sv
design/rover_top.sv
verif/rover_tb.sv
